// File: hdl/forth_macros.svh
`ifndef FORTH_MACROS_SVH
`define FORTH_MACROS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// One stack cell and one program word
`define FORTH_DATA_W 32
// Opcode taken from the low bits of a word
`define FORTH_OP_W 16

// Program memory, one word per address
`define FORTH_MEM_DEPTH 256
`define FORTH_ADDR_W 8

// Circular data stack
`define FORTH_STACK_DEPTH 16

// Clocks per serial bit, kept short for simulation
`define FORTH_BIT_CYCLES 8

////////////////////////////////////////
// APB register map
////////////////////////////////////////

// Below 0x400 the bus sees program words
`define FORTH_REG_CTRL 12'h400
`define FORTH_REG_PC 12'h404
`define FORTH_REG_TOS 12'h408
`define FORTH_REG_DEPTH 12'h40C

`endif

// File: hdl/forth_isa_pkg.sv
`include "forth_macros.svh"

package forth_isa_pkg;

	// Opcode numbering, groups kept in their historical order
	typedef enum logic [`FORTH_OP_W-1:0] {
		// System words
		op_execute, op_abort, op_end_boot, op_run_boot, op_create, op_does,
		op_compile, op_bracket_compile, op_interpret, op_do_colon, op_exit, op_number,
		// Stack words
		op_depth, op_dup, op_pick, op_over, op_swap, op_rot, op_equal, op_zero_equal,
		op_greater_than, op_less_than, op_question_dup, op_drop, op_roll,
		op_to_return, op_from_return, op_copy_return, op_lit,
		// Memory words
		op_8store, op_8fetch, op_8plus_store, op_16store, op_16fetch, op_32store,
		op_32fetch, op_cmove, op_fill, op_rom_active, op_sram_active, op_exsram_active,
		// Arithmetic
		op_plus, op_minus, op_times, op_divide, op_max, op_min, op_times_mod,
		op_divide_mod, op_times_divide, op_one_plus, op_one_minus, op_negate,
		// Conditionals and loops
		op_if, op_else, op_then, op_0branch, op_branch,
		op_begin, op_again, op_until, op_for, op_next,
		// Logic
		op_and, op_or, op_xor, op_not, op_zero_less_than, op_zero_greater_than,
		op_zero_equals,
		// Serial and board I/O
		op_key, op_emit, op_io_led, op_io_button, op_io_fetch, op_io_store
	} op_e;

	// Word presented by fetch, tagged with its address
	typedef struct packed {
		logic valid;
		logic [`FORTH_ADDR_W-1:0] pc;
		logic [`FORTH_DATA_W-1:0] word;
	} fetch_item_t;

	// Taken branch back to fetch
	typedef struct packed {
		logic valid;
		logic [`FORTH_ADDR_W-1:0] target;
	} redirect_t;

endpackage

// File: hdl/forth_bus_pkg.sv
`include "forth_macros.svh"

package forth_bus_pkg;

	// Host side of the APB slave
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [11:0] paddr;
		logic [`FORTH_DATA_W-1:0] pwdata;
	} apb_req_t;

	// Slave answer, valid in the access phase
	typedef struct packed {
		logic [`FORTH_DATA_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_resp_t;

	// Core state visible over the bus
	typedef struct packed {
		// Address of the last opcode executed
		logic [`FORTH_ADDR_W-1:0] pc;
		logic [`FORTH_DATA_W-1:0] tos;
		// 0 to 16 cells
		logic [$clog2(`FORTH_STACK_DEPTH):0] depth;
	} core_status_t;

endpackage

// File: hdl/forth_apb_regs.sv
`timescale 1ns/100ps
`include "forth_macros.svh"

module forth_apb_regs (
	input  logic clk,
	input  logic reset,
	input  forth_bus_pkg::apb_req_t apb_req,
	input  forth_bus_pkg::core_status_t status,
	input  logic [`FORTH_DATA_W-1:0] mem_rdata,
	output forth_bus_pkg::apb_resp_t apb_resp,
	output logic mem_we,
	output logic [`FORTH_ADDR_W-1:0] mem_addr,
	output logic [`FORTH_DATA_W-1:0] mem_wdata,
	output logic run,
	output logic start
);

	logic access;
	logic is_prog;
	logic is_ctrl;
	logic is_pc;
	logic is_tos;
	logic is_depth;
	logic mapped;
	logic ctrl_wr;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	// Second cycle of a transfer
	assign access = apb_req.psel && apb_req.penable;

	assign is_prog = apb_req.paddr < `FORTH_REG_CTRL;
	assign is_ctrl = apb_req.paddr == `FORTH_REG_CTRL;
	assign is_pc = apb_req.paddr == `FORTH_REG_PC;
	assign is_tos = apb_req.paddr == `FORTH_REG_TOS;
	assign is_depth = apb_req.paddr == `FORTH_REG_DEPTH;
	assign mapped = is_prog || is_ctrl || is_pc || is_tos || is_depth;

	// Word address, held from setup so the registered read is ready in access
	assign mem_addr = apb_req.paddr[`FORTH_ADDR_W+1:2];
	assign mem_wdata = apb_req.pwdata;
	// Program is frozen while the core runs
	assign mem_we = access && apb_req.pwrite && is_prog && !run;

	assign ctrl_wr = access && apb_req.pwrite && is_ctrl;

	////////////////////////////////////////
	// Run control
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			run <= 1'b0;
			start <= 1'b0;
		end else begin
			// Writing 1 restarts from address 0 with an empty stack
			start <= ctrl_wr && apb_req.pwdata[0];
			if (ctrl_wr) begin
				run <= apb_req.pwdata[0];
			end
		end
	end

	// Read mux and response
	always_comb begin
		apb_resp.prdata = '0;
		if (is_prog) begin
			apb_resp.prdata = mem_rdata;
		end else if (is_ctrl) begin
			apb_resp.prdata[0] = run;
		end else if (is_pc) begin
			apb_resp.prdata[`FORTH_ADDR_W-1:0] = status.pc;
		end else if (is_tos) begin
			apb_resp.prdata = status.tos;
		end else if (is_depth) begin
			apb_resp.prdata[$bits(status.depth)-1:0] = status.depth;
		end
		// No wait states
		apb_resp.pready = access;
		apb_resp.pslverr = access && (!mapped || (apb_req.pwrite && is_prog && run));
	end

	// Every completed transfer had a setup phase just before it
	a_apb_phases: assert property (@(posedge clk) disable iff (!reset)
		apb_resp.pready |-> apb_req.psel && apb_req.penable
			&& $past(apb_req.psel && !apb_req.penable));

endmodule

// File: hdl/forth_fetch.sv
`timescale 1ns/100ps
`include "forth_macros.svh"

module forth_fetch (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic start,
	input  logic stall,
	input  forth_isa_pkg::redirect_t redirect,
	input  logic mem_we,
	input  logic [`FORTH_ADDR_W-1:0] mem_addr,
	input  logic [`FORTH_DATA_W-1:0] mem_wdata,
	output forth_isa_pkg::fetch_item_t item,
	output logic [`FORTH_DATA_W-1:0] mem_rdata
);

	logic [`FORTH_DATA_W-1:0] mem [`FORTH_MEM_DEPTH];
	// Address issued this cycle
	logic [`FORTH_ADDR_W-1:0] pc;
	logic issue;
	logic item_valid;
	logic [`FORTH_ADDR_W-1:0] item_pc;
	logic [`FORTH_DATA_W-1:0] item_word;

	////////////////////////////////////////
	// Program memory
	////////////////////////////////////////

	// Bus port, write and registered read
	always_ff @(posedge clk) begin
		if (mem_we) begin
			mem[mem_addr] <= mem_wdata;
		end
		mem_rdata <= mem[mem_addr];
	end

	// New address only when nothing overrides the sequence
	assign issue = run && !stall && !start && !redirect.valid;

	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
		end else if (start) begin
			pc <= '0;
		end else if (redirect.valid) begin
			pc <= redirect.target;
		end else if (issue) begin
			pc <= pc + 1'b1;
		end
	end

	// Presented word, held under stall
	always_ff @(posedge clk) begin
		if (!reset) begin
			item_valid <= 1'b0;
		end else if (start || redirect.valid) begin
			// Drop the word from the old path
			item_valid <= 1'b0;
		end else if (!stall) begin
			item_valid <= run;
		end
	end

	// Core read port
	always_ff @(posedge clk) begin
		if (issue) begin
			item_pc <= pc;
			item_word <= mem[pc];
		end
	end

	assign item = '{valid: item_valid, pc: item_pc, word: item_word};

	// Execute never redirects while it holds the pipe
	a_stall_holds_pc: assert property (@(posedge clk) disable iff (!reset)
		stall && !start |=> $stable(pc));

endmodule

// File: hdl/forth_execute.sv
`timescale 1ns/100ps
`include "forth_macros.svh"

module forth_execute (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  forth_isa_pkg::fetch_item_t item,
	input  logic tx_busy,
	output logic stall,
	output forth_isa_pkg::redirect_t redirect,
	output forth_bus_pkg::core_status_t status,
	output logic [2:0] led,
	output logic tx_start,
	output logic [7:0] tx_byte
);
	import forth_isa_pkg::*;

	localparam int sp_w = $clog2(`FORTH_STACK_DEPTH);
	localparam int depth_w = sp_w + 1;
	localparam logic [depth_w-1:0] depth_max = depth_w'(`FORTH_STACK_DEPTH);

	typedef enum logic [1:0] {emit_idle, emit_rise, emit_fall} emit_e;

	// Cells below TOS, sp points at NOS
	logic [`FORTH_DATA_W-1:0] stack [`FORTH_STACK_DEPTH];
	logic [sp_w-1:0] sp;
	logic [sp_w-1:0] sp_up;
	logic [depth_w-1:0] depth;
	logic [`FORTH_DATA_W-1:0] tos;
	logic [`FORTH_DATA_W-1:0] nos;
	logic [`FORTH_DATA_W-1:0] below;
	logic [`FORTH_DATA_W-1:0] tos_next;
	logic pending;
	op_e pend_op;
	op_e op;
	emit_e emit_state;
	logic consume;
	logic is_emit;
	logic do_push;
	logic do_pop;
	logic [`FORTH_ADDR_W-1:0] last_pc;

	assign op = op_e'(item.word[`FORTH_OP_W-1:0]);
	assign nos = stack[sp];
	assign sp_up = sp + 1'b1;
	// Value left on top after a pop, zero once empty
	assign below = (depth > depth_w'(1)) ? nos : '0;

	// Hold fetch during a frame, or while an old frame still runs
	assign stall = (emit_state != emit_idle)
		|| (item.valid && !pending && op == op_emit && tx_busy);
	assign consume = item.valid && !stall && !start;
	assign is_emit = consume && !pending && op == op_emit;

	// Branch operand resolves here, 0branch tests the flag still on top
	always_comb begin
		redirect.valid = consume && pending
			&& (pend_op == op_branch || (pend_op == op_0branch && tos == '0));
		redirect.target = item.word[`FORTH_ADDR_W-1:0];
	end

	////////////////////////////////////////
	// Stack effect of each word
	////////////////////////////////////////

	always_comb begin
		do_push = 1'b0;
		do_pop = 1'b0;
		tos_next = tos;
		if (pending) begin
			if (pend_op == op_lit) begin
				do_push = 1'b1;
				tos_next = item.word;
			end else if (pend_op == op_0branch) begin
				// Flag goes either way
				do_pop = 1'b1;
				tos_next = below;
			end
		end else begin
			case (op)
				op_plus: begin
					do_pop = 1'b1;
					tos_next = nos + tos;
				end
				op_minus: begin
					do_pop = 1'b1;
					tos_next = nos - tos;
				end
				op_and: begin
					do_pop = 1'b1;
					tos_next = nos & tos;
				end
				op_or: begin
					do_pop = 1'b1;
					tos_next = nos | tos;
				end
				op_equal: begin
					do_pop = 1'b1;
					tos_next = (nos == tos) ? '1 : '0;
				end
				op_drop, op_io_led, op_emit: begin
					do_pop = 1'b1;
					tos_next = below;
				end
				op_dup: do_push = 1'b1;
				op_over: begin
					do_push = 1'b1;
					tos_next = nos;
				end
				op_not: tos_next = ~tos;
				op_negate: tos_next = -tos;
				op_zero_equal: tos_next = (tos == '0) ? '1 : '0;
				// Sign bit spread over the cell
				op_zero_less_than: tos_next = {`FORTH_DATA_W{tos[`FORTH_DATA_W-1]}};
				default: tos_next = tos;
			endcase
		end
	end

	// Old TOS sinks into the array on a push
	always_ff @(posedge clk) begin
		if (consume && do_push) begin
			stack[sp_up] <= tos;
		end
		if (is_emit) begin
			tx_byte <= tos[7:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset || start) begin
			sp <= '0;
			depth <= '0;
			tos <= '0;
			pending <= 1'b0;
			pend_op <= op_execute;
			last_pc <= '0;
		end else if (consume) begin
			tos <= tos_next;
			if (do_push) begin
				sp <= sp_up;
				depth <= (depth == depth_max) ? depth : depth + 1'b1;
			end else if (do_pop) begin
				sp <= sp - 1'b1;
				depth <= (depth == '0) ? depth : depth - 1'b1;
			end
			if (pending) begin
				pending <= 1'b0;
			end else begin
				// Next word is data for these
				pending <= op == op_lit || op == op_branch || op == op_0branch;
				pend_op <= op;
				last_pc <= item.pc;
			end
		end
	end

	////////////////////////////////////////
	// Emit handshake and LEDs
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			emit_state <= emit_idle;
			tx_start <= 1'b0;
			led <= 3'b111;
		end else begin
			tx_start <= 1'b0;
			if (start) begin
				emit_state <= emit_idle;
			end else begin
				case (emit_state)
					emit_idle: begin
						if (is_emit) begin
							tx_start <= 1'b1;
							emit_state <= emit_rise;
						end
					end
					emit_rise: if (tx_busy) emit_state <= emit_fall;
					// Falling busy ends the word
					emit_fall: if (!tx_busy) emit_state <= emit_idle;
					default: emit_state <= emit_idle;
				endcase
			end
			// LEDs are active low
			if (consume && !pending && op == op_io_led) begin
				led <= ~tos[2:0];
			end
		end
	end

	assign status = '{pc: last_pc, tos: tos, depth: depth};

	// A new frame only starts on an idle transmitter
	a_tx_start_idle: assert property (@(posedge clk) disable iff (!reset)
		tx_start |-> !tx_busy);

endmodule

// File: hdl/forth_uart_tx.sv
`timescale 1ns/100ps
`include "forth_macros.svh"

module forth_uart_tx (
	input  logic clk,
	input  logic reset,
	input  logic tx_start,
	input  logic [7:0] tx_byte,
	output logic tx,
	output logic tx_busy
);

	localparam int cyc_w = $clog2(`FORTH_BIT_CYCLES);
	localparam logic [cyc_w-1:0] cyc_last = cyc_w'(`FORTH_BIT_CYCLES - 1);

	logic [cyc_w-1:0] cyc_cnt;
	logic [3:0] bit_cnt;
	// Stop, data LSB first, start bit at the bottom
	logic [9:0] frame;

	// Line idles high through the ones shifted in
	assign tx = frame[0];

	always_ff @(posedge clk) begin
		if (!reset) begin
			tx_busy <= 1'b0;
			cyc_cnt <= '0;
			bit_cnt <= '0;
			frame <= '1;
		end else if (!tx_busy) begin
			cyc_cnt <= '0;
			bit_cnt <= '0;
			if (tx_start) begin
				frame <= {1'b1, tx_byte, 1'b0};
				tx_busy <= 1'b1;
			end
		end else if (cyc_cnt == cyc_last) begin
			// End of one bit time
			cyc_cnt <= '0;
			frame <= {1'b1, frame[9:1]};
			if (bit_cnt == 4'd9) begin
				// Stop bit done
				tx_busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

endmodule

// File: hdl/forth_core.sv
`timescale 1ns/100ps
`include "forth_macros.svh"

module forth_core (
	input  logic clk,
	input  logic reset,
	input  forth_bus_pkg::apb_req_t apb_req,
	output forth_bus_pkg::apb_resp_t apb_resp,
	output logic tx,
	output logic [2:0] led
);
	import forth_isa_pkg::*;
	import forth_bus_pkg::*;

	// Bus to program memory
	logic mem_we;
	logic [`FORTH_ADDR_W-1:0] mem_addr;
	logic [`FORTH_DATA_W-1:0] mem_wdata;
	logic [`FORTH_DATA_W-1:0] mem_rdata;
	logic run;
	logic start;

	// Pipeline
	fetch_item_t item;
	redirect_t redirect;
	logic stall;
	core_status_t status;

	// Emit path
	logic tx_start;
	logic [7:0] tx_byte;
	logic tx_busy;

	forth_apb_regs i_regs (
		.clk(clk), .reset(reset), .apb_req(apb_req), .status(status),
		.mem_rdata(mem_rdata), .apb_resp(apb_resp), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .run(run), .start(start)
	);

	forth_fetch i_fetch (
		.clk(clk), .reset(reset), .run(run), .start(start), .stall(stall),
		.redirect(redirect), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .item(item), .mem_rdata(mem_rdata)
	);

	forth_execute i_execute (
		.clk(clk), .reset(reset), .start(start), .item(item), .tx_busy(tx_busy),
		.stall(stall), .redirect(redirect), .status(status), .led(led),
		.tx_start(tx_start), .tx_byte(tx_byte)
	);

	forth_uart_tx i_uart_tx (
		.clk(clk), .reset(reset), .tx_start(tx_start), .tx_byte(tx_byte),
		.tx(tx), .tx_busy(tx_busy)
	);

endmodule

// File: tests/forth_core_tb.sv
`timescale 1ns/100ps
`include "forth_macros.svh"

module forth_core_tb;
	import forth_isa_pkg::*;
	import forth_bus_pkg::*;

	localparam int n_rows = 16;
	localparam int poll_limit = 200;
	// Bit centres seen from the negedge after the start edge
	localparam int half_bit = `FORTH_BIT_CYCLES / 2;
	localparam int frame_end = half_bit + 9 * `FORTH_BIT_CYCLES;

	// Table entry, lit A then maybe lit B, then op
	typedef struct packed {
		op_e op;
		logic [1:0] n_lit;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] exp_tos;
		logic [4:0] exp_depth;
	} row_t;

	logic clk;
	logic reset;
	apb_req_t apb_req;
	apb_resp_t apb_resp;
	logic tx;
	logic [2:0] led;

	integer errors;
	integer checks;
	integer seed;
	row_t rows [n_rows];
	// Program being assembled
	logic [31:0] prog [$];
	// Bytes caught on the serial line
	logic [7:0] rx_bytes [$];

	// UART monitor state
	int mon_cnt;
	logic mon_active;
	logic [7:0] mon_byte;

	forth_core i_dut (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_resp(apb_resp),
		.tx(tx),
		.led(led)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("FAILED %s: expected %h, got %h", name, expected, got);
		end
	endtask

	// Expected stack by the Forth rules
	function automatic row_t make_row(input op_e op, input logic [1:0] n_lit,
		input logic [31:0] a, input logic [31:0] b);
		row_t r;
		r.op = op;
		r.n_lit = n_lit;
		r.a = a;
		r.b = b;
		r.exp_depth = 5'd1;
		case (op)
			op_plus: r.exp_tos = a + b;
			op_minus: r.exp_tos = a - b;
			op_and: r.exp_tos = a & b;
			op_or: r.exp_tos = a | b;
			op_equal: r.exp_tos = (a == b) ? '1 : '0;
			op_not: r.exp_tos = ~a;
			op_negate: r.exp_tos = -a;
			op_zero_equal: r.exp_tos = (a == 32'h0) ? '1 : '0;
			// True for negative cells
			op_zero_less_than: r.exp_tos = a[31] ? '1 : '0;
			op_dup: begin
				r.exp_tos = a;
				r.exp_depth = 5'd2;
			end
			op_drop: r.exp_tos = a;
			op_over: begin
				r.exp_tos = a;
				r.exp_depth = 5'd3;
			end
			default: begin
				// Unknown codes leave the literals alone
				r.exp_tos = (n_lit == 2'd2) ? b : a;
				r.exp_depth = {3'h0, n_lit};
			end
		endcase
		return r;
	endfunction

	// One APB transfer, setup then access, sampled mid access phase
	task automatic apb_access(input logic write, input logic [11:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		@(negedge clk);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#1;
		check_value("pready", {31'h0, apb_resp.pready}, 32'h1);
		rdata = apb_resp.prdata;
		slverr = apb_resp.pslverr;
		@(negedge clk);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		logic err;
		apb_access(1'b1, addr, wdata, unused, err);
		check_value("pslverr", {31'h0, err}, 32'h0);
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata);
		logic err;
		apb_access(1'b0, addr, 32'h0, rdata, err);
		check_value("pslverr", {31'h0, err}, 32'h0);
	endtask

	task automatic add_word(input logic [31:0] w);
		prog.push_back(w);
	endtask

	task automatic add_op(input op_e op);
		prog.push_back({16'h0, op});
	endtask

	// Close with branch-to-self, load, start, poll PC for the loop
	task automatic run_program(output logic ok);
		logic [31:0] pc_val;
		int end_addr;
		int polls;
		int i;
		end_addr = prog.size();
		add_op(op_branch);
		add_word(end_addr);
		apb_write(`FORTH_REG_CTRL, 32'h0);
		for (i = 0; i < prog.size(); i++) begin
			apb_write(12'(i * 4), prog[i]);
		end
		prog.delete();
		apb_write(`FORTH_REG_CTRL, 32'h1);
		ok = 1'b0;
		polls = 0;
		while (!ok && polls < poll_limit) begin
			apb_read(`FORTH_REG_PC, pc_val);
			ok = (pc_val == 32'(end_addr));
			polls++;
		end
		if (!ok) begin
			errors++;
			$display("Timeout: PC never reached the closing branch at %0d", end_addr);
		end
	endtask

	////////////////////////////////////////
	// Check groups
	////////////////////////////////////////

	task automatic check_reset_state();
		logic [31:0] data;
		logic [31:0] word;
		check_value("tx", {31'h0, tx}, 32'h1);
		check_value("led", {29'h0, led}, 32'h7);
		apb_read(`FORTH_REG_PC, data);
		check_value("PC", data, 32'h0);
		apb_read(`FORTH_REG_TOS, data);
		check_value("TOS", data, 32'h0);
		apb_read(`FORTH_REG_DEPTH, data);
		check_value("DEPTH", data, 32'h0);
		// Top program word, out of the way of test programs
		word = $random(seed);
		apb_write(12'h3FC, word);
		apb_read(12'h3FC, data);
		check_value("program word 255", data, word);
	endtask

	// Marker runs only for a nonzero flag
	task automatic check_zero_branch(input logic [31:0] flag);
		logic [31:0] data;
		logic ok;
		add_op(op_lit);
		add_word(flag);
		add_op(op_0branch);
		add_word(32'd6);
		add_op(op_lit);
		add_word(32'h0000_C0DE);
		run_program(ok);
		apb_read(`FORTH_REG_TOS, data);
		check_value("TOS after 0branch", data, (flag == 32'h0) ? 32'h0 : 32'h0000_C0DE);
		apb_read(`FORTH_REG_DEPTH, data);
		check_value("DEPTH after 0branch", data, (flag == 32'h0) ? 32'h0 : 32'h1);
	endtask

	task automatic check_leds(input logic [31:0] n);
		logic [31:0] data;
		logic ok;
		add_op(op_lit);
		add_word(n);
		add_op(op_io_led);
		run_program(ok);
		// Active low
		check_value("led", {29'h0, led}, {29'h0, ~n[2:0]});
		apb_read(`FORTH_REG_DEPTH, data);
		check_value("DEPTH after io_led", data, 32'h0);
	endtask

	// Two emits in a row, then bus errors while still running
	task automatic check_emit(input logic [7:0] b0, input logic [7:0] b1);
		logic [31:0] data;
		logic ok;
		logic err;
		int waited;
		rx_bytes.delete();
		add_op(op_lit);
		add_word({24'h0, b0});
		add_op(op_emit);
		add_op(op_lit);
		add_word({24'h0, b1});
		add_op(op_emit);
		run_program(ok);
		waited = 0;
		while (rx_bytes.size() < 2 && waited < 400) begin
			@(negedge clk);
			waited++;
		end
		if (rx_bytes.size() < 2) begin
			errors++;
			$display("Timeout: only %0d of 2 UART frames arrived", rx_bytes.size());
		end else begin
			check_value("tx frame 0", {24'h0, rx_bytes[0]}, {24'h0, b0});
			check_value("tx frame 1", {24'h0, rx_bytes[1]}, {24'h0, b1});
		end
		apb_read(`FORTH_REG_DEPTH, data);
		check_value("DEPTH after emit", data, 32'h0);
		// Word 2 holds the first emit
		apb_access(1'b1, 12'h008, 32'hFFFF_FFFF, data, err);
		check_value("pslverr on program write", {31'h0, err}, 32'h1);
		apb_read(12'h008, data);
		check_value("program word 2", data, {16'h0, op_emit});
		apb_access(1'b0, 12'h500, 32'h0, data, err);
		check_value("pslverr on unmapped read", {31'h0, err}, 32'h1);
		apb_write(`FORTH_REG_CTRL, 32'h0);
	endtask

	////////////////////////////////////////
	// UART monitor
	////////////////////////////////////////

	initial begin
		mon_active = 1'b0;
		mon_cnt = 0;
		mon_byte = '0;
		forever begin
			@(negedge clk);
			if (!mon_active) begin
				// Falling line starts a frame
				if (reset === 1'b1 && tx === 1'b0) begin
					mon_active = 1'b1;
					mon_cnt = 0;
				end
			end else begin
				mon_cnt++;
				if (mon_cnt == half_bit) begin
					check_value("tx start bit", {31'h0, tx}, 32'h0);
				end else if (mon_cnt == frame_end) begin
					check_value("tx stop bit", {31'h0, tx}, 32'h1);
					rx_bytes.push_back(mon_byte);
					mon_active = 1'b0;
				end else if ((mon_cnt - half_bit) % `FORTH_BIT_CYCLES == 0) begin
					// LSB first
					mon_byte[(mon_cnt - half_bit) / `FORTH_BIT_CYCLES - 1] = tx;
				end
			end
		end
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] data;
		logic [31:0] x;
		logic ok;
		int r;
		errors = 0;
		checks = 0;
		seed = 87;
		reset = 1'b0;
		apb_req = '0;
		repeat (10) @(negedge clk);
		reset = 1'b1;

		check_reset_state();

		// Binary rows
		rows[0] = make_row(op_plus, 2'd2, $random(seed), $random(seed));
		rows[1] = make_row(op_minus, 2'd2, $random(seed), $random(seed));
		rows[2] = make_row(op_and, 2'd2, $random(seed), $random(seed));
		rows[3] = make_row(op_or, 2'd2, $random(seed), $random(seed));
		rows[4] = make_row(op_equal, 2'd2, $random(seed), $random(seed));
		x = $random(seed);
		rows[5] = make_row(op_equal, 2'd2, x, x);
		// Unary rows, both flag outcomes
		rows[6] = make_row(op_not, 2'd1, $random(seed), 32'h0);
		rows[7] = make_row(op_negate, 2'd1, $random(seed), 32'h0);
		rows[8] = make_row(op_zero_equal, 2'd1, $random(seed) | 32'h1, 32'h0);
		rows[9] = make_row(op_zero_equal, 2'd1, 32'h0, 32'h0);
		x = $random(seed);
		rows[10] = make_row(op_zero_less_than, 2'd1, x | 32'h8000_0000, 32'h0);
		rows[11] = make_row(op_zero_less_than, 2'd1, x & 32'h7FFF_FFFF, 32'h0);
		// Stack rows
		rows[12] = make_row(op_dup, 2'd1, $random(seed), 32'h0);
		rows[13] = make_row(op_drop, 2'd2, $random(seed), $random(seed));
		rows[14] = make_row(op_over, 2'd2, $random(seed), $random(seed));
		// Unkept code acts as a no-op
		rows[15] = make_row(op_swap, 2'd2, $random(seed), $random(seed));

		for (r = 0; r < n_rows; r++) begin
			add_op(op_lit);
			add_word(rows[r].a);
			if (rows[r].n_lit == 2'd2) begin
				add_op(op_lit);
				add_word(rows[r].b);
			end
			add_op(rows[r].op);
			run_program(ok);
			if (ok) begin
				apb_read(`FORTH_REG_TOS, data);
				check_value($sformatf("TOS row %0d", r), data, rows[r].exp_tos);
				apb_read(`FORTH_REG_DEPTH, data);
				check_value($sformatf("DEPTH row %0d", r), data, {27'h0, rows[r].exp_depth});
			end
		end

		check_zero_branch(32'h0);
		check_zero_branch($random(seed) | 32'h1);

		for (r = 0; r < 3; r++) begin
			check_leds($random(seed));
		end

		x = $random(seed);
		check_emit(x[7:0], x[15:8]);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: forth_core.f
+incdir+hdl
hdl/forth_isa_pkg.sv
hdl/forth_bus_pkg.sv
hdl/forth_apb_regs.sv
hdl/forth_fetch.sv
hdl/forth_execute.sv
hdl/forth_uart_tx.sv
hdl/forth_core.sv
tests/forth_core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the forth_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module forth_core_tb -f forth_core.f
out=$(./obj_dir/Vforth_core_tb)
echo "$out"
if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
